// File: rtl/dp_pkg.sv
package dp_pkg;

	localparam int NUM_SRC = 24;
	localparam int NUM_DST = 23;

	typedef logic [31:0] word_t;
	typedef logic [63:0] wide_t;
	typedef logic [NUM_SRC-1:0] src_mask_t;
	typedef logic [NUM_DST-1:0] dst_mask_t;
	typedef logic [4:0] src_idx_t;

	// source bit positions, R0..R15 are consecutive from SRC_R0.
	localparam src_idx_t SRC_R0 = 5'd0;
	localparam src_idx_t SRC_HI = 5'd16;
	localparam src_idx_t SRC_LO = 5'd17;
	localparam src_idx_t SRC_ZHI = 5'd18;
	localparam src_idx_t SRC_ZLO = 5'd19;
	localparam src_idx_t SRC_PC = 5'd20;
	localparam src_idx_t SRC_MDR = 5'd21;
	localparam src_idx_t SRC_INPORT = 5'd22;
	localparam src_idx_t SRC_C = 5'd23;

	// destination load enables.
	localparam int DST_R0 = 0;
	localparam int DST_HI = 16;
	localparam int DST_LO = 17;
	localparam int DST_PC = 18;
	localparam int DST_MDR = 19;
	localparam int DST_Y = 20;
	localparam int DST_Z = 21;
	localparam int DST_OUTPORT = 22;

	typedef enum logic [3:0] {
		ADD = 4'd0,
		SUB = 4'd1,
		AND = 4'd2,
		OR  = 4'd3,
		SHL = 4'd4,
		SHR = 4'd5,
		ROL = 4'd6,
		ROR = 4'd7,
		MUL = 4'd8,
		DIV = 4'd9,
		NEG = 4'd10,
		NOT = 4'd11
	} alu_op_e;

	typedef struct packed {
		src_mask_t src;
		dst_mask_t dst;
		alu_op_e op;
		logic [15:0] imm;
	} micro_op_t;

	typedef struct packed {
		word_t [15:0] r;
		word_t hi;
		word_t lo;
		wide_t z;
		word_t pc;
		word_t mdr;
		word_t inport;
	} bank_out_t;

endpackage

// File: rtl/wb_map_pkg.sv
package wb_map_pkg;

	localparam int WB_AW = 3;

	// word addresses.
	localparam logic [WB_AW-1:0] ADDR_INPORT = 3'd0;
	localparam logic [WB_AW-1:0] ADDR_SRC = 3'd1;
	localparam logic [WB_AW-1:0] ADDR_DST = 3'd2;
	// opcode in [3:0], immediate in [31:16].
	localparam logic [WB_AW-1:0] ADDR_EXEC = 3'd3;
	localparam logic [WB_AW-1:0] ADDR_OUTPORT = 3'd4;
	localparam logic [WB_AW-1:0] ADDR_BUS = 3'd5;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [WB_AW-1:0] adr;
		dp_pkg::word_t dat;
	} wb_req_t;

endpackage

// File: rtl/wb_micro_port.sv
module wb_micro_port
(
	input  logic                clk,
	input  logic                rst_n,
	input  wb_map_pkg::wb_req_t req,
	input  dp_pkg::word_t       outport,
	input  dp_pkg::word_t       last_bus,
	output logic                ack,
	output dp_pkg::word_t       rdat,
	output dp_pkg::micro_op_t   uop,
	output logic                step,
	output logic                inport_ld,
	output dp_pkg::word_t       inport_val
);

	logic fire;
	logic wr;
	dp_pkg::word_t rd_mux;

	// no back-to-back acks, so a held stb is taken every other cycle.
	assign fire = req.cyc & req.stb & ~ack;
	assign wr = fire & req.we;

	always_comb
	begin
		case (req.adr)
			wb_map_pkg::ADDR_OUTPORT: rd_mux = outport;
			wb_map_pkg::ADDR_BUS: rd_mux = last_bus;
			default: rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ack <= 1'b0;
			step <= 1'b0;
			inport_ld <= 1'b0;
			uop <= '0;
		end
		else
		begin
			ack <= fire;
			step <= wr & (req.adr == wb_map_pkg::ADDR_EXEC);
			inport_ld <= wr & (req.adr == wb_map_pkg::ADDR_INPORT);
			if (wr)
			begin
				case (req.adr)
					wb_map_pkg::ADDR_SRC: uop.src <= req.dat[dp_pkg::NUM_SRC-1:0];
					wb_map_pkg::ADDR_DST: uop.dst <= req.dat[dp_pkg::NUM_DST-1:0];
					wb_map_pkg::ADDR_EXEC:
					begin
						uop.op <= dp_pkg::alu_op_e'(req.dat[3:0]);
						uop.imm <= req.dat[31:16];
					end
					default: ;
				endcase
			end
		end
	end

	// read data lines up with ack.
	always_ff @(posedge clk)
	begin
		if (fire)
		begin
			rdat <= req.we ? '0 : rd_mux;
			inport_val <= req.dat;
		end
	end

endmodule

// File: rtl/reg_bank.sv
module reg_bank
(
	input  logic                clk,
	input  logic                rst_n,
	input  logic                step,
	input  dp_pkg::dst_mask_t   dst,
	input  dp_pkg::word_t       bus,
	input  dp_pkg::wide_t       alu_result,
	input  logic                inport_ld,
	input  dp_pkg::word_t       inport_val,
	output dp_pkg::bank_out_t   regs,
	output dp_pkg::word_t       y,
	output dp_pkg::word_t       outport,
	output dp_pkg::word_t       last_bus
);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			regs <= '0;
			y <= '0;
			outport <= '0;
			last_bus <= '0;
		end
		else
		begin
			// inport only loads from the host side.
			if (inport_ld)
			begin
				regs.inport <= inport_val;
			end
			if (step)
			begin
				for (int i = 0; i < 16; i++)
				begin
					if (dst[dp_pkg::DST_R0 + i])
					begin
						regs.r[i] <= bus;
					end
				end
				if (dst[dp_pkg::DST_HI])
				begin
					regs.hi <= bus;
				end
				if (dst[dp_pkg::DST_LO])
				begin
					regs.lo <= bus;
				end
				if (dst[dp_pkg::DST_PC])
				begin
					regs.pc <= bus;
				end
				if (dst[dp_pkg::DST_MDR])
				begin
					regs.mdr <= bus;
				end
				if (dst[dp_pkg::DST_Y])
				begin
					y <= bus;
				end
				// z takes the alu result, not the bus.
				if (dst[dp_pkg::DST_Z])
				begin
					regs.z <= alu_result;
				end
				if (dst[dp_pkg::DST_OUTPORT])
				begin
					outport <= bus;
				end
				last_bus <= bus;
			end
		end
	end

endmodule

// File: rtl/bus_mux.sv
module bus_mux
(
	input  dp_pkg::src_mask_t   sel,
	input  dp_pkg::bank_out_t   regs,
	input  logic [15:0]         imm,
	output dp_pkg::word_t       bus
);

	dp_pkg::src_idx_t idx;
	dp_pkg::src_idx_t r_off;
	dp_pkg::word_t c_ext;
	logic hit;

	assign c_ext = {{16{imm[15]}}, imm};

	// downward scan, so the lowest set bit wins.
	always_comb
	begin
		idx = '0;
		hit = 1'b0;
		for (int i = dp_pkg::NUM_SRC - 1; i >= 0; i--)
		begin
			if (sel[i])
			begin
				idx = dp_pkg::src_idx_t'(i);
				hit = 1'b1;
			end
		end
	end

	assign r_off = idx - dp_pkg::SRC_R0;

	always_comb
	begin
		if (!hit)
			bus = '0;
		else
		begin
			case (idx)
				dp_pkg::SRC_HI: bus = regs.hi;
				dp_pkg::SRC_LO: bus = regs.lo;
				dp_pkg::SRC_ZHI: bus = regs.z[63:32];
				dp_pkg::SRC_ZLO: bus = regs.z[31:0];
				dp_pkg::SRC_PC: bus = regs.pc;
				dp_pkg::SRC_MDR: bus = regs.mdr;
				dp_pkg::SRC_INPORT: bus = regs.inport;
				dp_pkg::SRC_C: bus = c_ext;
				default: bus = regs.r[r_off[3:0]];
			endcase
		end
	end

endmodule

// File: rtl/alu.sv
module alu
(
	input  dp_pkg::alu_op_e     op,
	input  dp_pkg::word_t       a,
	input  dp_pkg::word_t       b,
	output dp_pkg::wide_t       result
);

	logic signed [63:0] prod;
	dp_pkg::word_t quot;
	dp_pkg::word_t rem;
	dp_pkg::wide_t rol_t;
	dp_pkg::wide_t ror_t;
	logic [4:0] sh;

	assign sh = b[4:0];
	assign prod = $signed(a) * $signed(b);

	// divide by zero yields zero in both halves.
	assign quot = (b == '0) ? '0 : dp_pkg::word_t'($signed(a) / $signed(b));
	assign rem = (b == '0) ? '0 : dp_pkg::word_t'($signed(a) % $signed(b));

	// rotates via a doubled word.
	assign rol_t = {a, a} << sh;
	assign ror_t = {a, a} >> sh;

	always_comb
	begin
		result = '0;
		case (op)
			dp_pkg::ADD: result[31:0] = a + b;
			dp_pkg::SUB: result[31:0] = a - b;
			dp_pkg::AND: result[31:0] = a & b;
			dp_pkg::OR: result[31:0] = a | b;
			dp_pkg::SHL: result[31:0] = a << sh;
			dp_pkg::SHR: result[31:0] = a >> sh;
			dp_pkg::ROL: result[31:0] = rol_t[63:32];
			dp_pkg::ROR: result[31:0] = ror_t[31:0];
			dp_pkg::MUL: result = prod;
			dp_pkg::DIV: result = {rem, quot};
			dp_pkg::NEG: result[31:0] = -b;
			// unary on the bus operand.
			dp_pkg::NOT: result[31:0] = ~b;
			default: result = '0;
		endcase
	end

endmodule

// File: rtl/datapath_top.sv
module datapath_top
(
	input  logic                clk,
	input  logic                rst_n,
	input  wb_map_pkg::wb_req_t req,
	output logic                ack,
	output dp_pkg::word_t       rdat
);

	dp_pkg::micro_op_t uop;
	logic step;
	logic inport_ld;
	dp_pkg::word_t inport_val;
	dp_pkg::word_t outport;
	dp_pkg::word_t last_bus;
	dp_pkg::bank_out_t regs;
	dp_pkg::word_t y;
	dp_pkg::word_t bus;
	dp_pkg::wide_t alu_result;

	wb_micro_port u_port (
		.clk        (clk),
		.rst_n      (rst_n),
		.req        (req),
		.outport    (outport),
		.last_bus   (last_bus),
		.ack        (ack),
		.rdat       (rdat),
		.uop        (uop),
		.step       (step),
		.inport_ld  (inport_ld),
		.inport_val (inport_val)
	);

	reg_bank u_bank (
		.clk        (clk),
		.rst_n      (rst_n),
		.step       (step),
		.dst        (uop.dst),
		.bus        (bus),
		.alu_result (alu_result),
		.inport_ld  (inport_ld),
		.inport_val (inport_val),
		.regs       (regs),
		.y          (y),
		.outport    (outport),
		.last_bus   (last_bus)
	);

	bus_mux u_mux (
		.sel  (uop.src),
		.regs (regs),
		.imm  (uop.imm),
		.bus  (bus)
	);

	alu u_alu (
		.op     (uop.op),
		.a      (y),
		.b      (bus),
		.result (alu_result)
	);

endmodule

// File: verification/datapath_sva.sv
module datapath_sva
(
	input logic                clk,
	input logic                rst_n,
	input wb_map_pkg::wb_req_t req,
	input logic                ack,
	input logic                step
);

	// one ack per request, never two in a row.
	ack_single: assert property (@(posedge clk) disable iff (!rst_n) ack |=> !ack)
		else $error("ack high for two consecutive cycles");

	ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
		ack |-> $past(req.cyc && req.stb))
		else $error("ack without a request in the previous cycle");

	// the step pulse sits inside the ack cycle.
	step_with_ack: assert property (@(posedge clk) disable iff (!rst_n) step |-> ack)
		else $error("step pulse outside an ack cycle");

endmodule

bind wb_micro_port datapath_sva u_sva (
	.clk   (clk),
	.rst_n (rst_n),
	.req   (req),
	.ack   (ack),
	.step  (step)
);

// File: verification/datapath_tb.sv
module datapath_tb;

	logic clk;
	logic rst_n;
	wb_map_pkg::wb_req_t req;
	logic ack;
	dp_pkg::word_t rdat;

	int errors;
	int checks;
	int timeouts;
	logic [31:0] lcg_state;
	// bank model, index 0..19 is R0..R15, HI, LO, PC, MDR.
	dp_pkg::word_t exp_regs [20];
	dp_pkg::word_t inport_model;

	datapath_top dut (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (req),
		.ack   (ack),
		.rdat  (rdat)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic dp_pkg::src_mask_t src_sel(input int bit_pos);
		return dp_pkg::src_mask_t'(1) << bit_pos;
	endfunction

	function automatic dp_pkg::dst_mask_t dst_sel(input int bit_pos);
		return dp_pkg::dst_mask_t'(1) << bit_pos;
	endfunction

	function automatic int bank_src(input int k);
		case (k)
			16: return int'(dp_pkg::SRC_HI);
			17: return int'(dp_pkg::SRC_LO);
			18: return int'(dp_pkg::SRC_PC);
			19: return int'(dp_pkg::SRC_MDR);
			default: return int'(dp_pkg::SRC_R0) + k;
		endcase
	endfunction

	function automatic int bank_dst(input int k);
		case (k)
			16: return dp_pkg::DST_HI;
			17: return dp_pkg::DST_LO;
			18: return dp_pkg::DST_PC;
			19: return dp_pkg::DST_MDR;
			default: return dp_pkg::DST_R0 + k;
		endcase
	endfunction

	// reference alu, zero high word unless noted.
	function automatic dp_pkg::wide_t expected_alu(input dp_pkg::alu_op_e op,
		input dp_pkg::word_t a, input dp_pkg::word_t b);
		longint sa;
		longint sb;
		int s;
		dp_pkg::word_t lo;
		dp_pkg::word_t hi;
		sa = longint'($signed(a));
		sb = longint'($signed(b));
		s = int'(b[4:0]);
		lo = '0;
		hi = '0;
		case (op)
			dp_pkg::ADD: lo = a + b;
			dp_pkg::SUB: lo = a - b;
			dp_pkg::AND: lo = a & b;
			dp_pkg::OR: lo = a | b;
			dp_pkg::SHL: lo = a << s;
			dp_pkg::SHR: lo = a >> s;
			dp_pkg::ROL: lo = (s == 0) ? a : ((a << s) | (a >> (32 - s)));
			dp_pkg::ROR: lo = (s == 0) ? a : ((a >> s) | (a << (32 - s)));
			dp_pkg::MUL: {hi, lo} = sa * sb;
			dp_pkg::DIV:
			begin
				if (b != '0)
				begin
					lo = dp_pkg::word_t'(sa / sb);
					hi = dp_pkg::word_t'(sa % sb);
				end
			end
			dp_pkg::NEG: lo = -b;
			dp_pkg::NOT: lo = ~b;
			default: lo = '0;
		endcase
		return {hi, lo};
	endfunction

	task automatic check_word(input dp_pkg::word_t got, input dp_pkg::word_t exp,
		input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL t=%0t %s: got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_op(input dp_pkg::alu_op_e op, input dp_pkg::word_t lo,
		input dp_pkg::word_t hi, input dp_pkg::wide_t exp);
		checks++;
		if ({hi, lo} !== exp)
		begin
			errors++;
			$display("FAIL t=%0t alu %s: got hi %h lo %h, expected hi %h lo %h",
				$time, op.name(), hi, lo, exp[63:32], exp[31:0]);
		end
	endtask

	// one classic cycle, held until ack.
	task automatic wb_cycle(input logic we, input logic [wb_map_pkg::WB_AW-1:0] adr,
		input dp_pkg::word_t dat, output dp_pkg::word_t rd);
		int n;
		@(posedge clk);
		req.cyc <= 1'b1;
		req.stb <= 1'b1;
		req.we <= we;
		req.adr <= adr;
		req.dat <= dat;
		n = 0;
		rd = '0;
		@(negedge clk);
		while (!ack && n < 20)
		begin
			@(negedge clk);
			n++;
		end
		if (ack)
			rd = rdat;
		else
		begin
			timeouts++;
			$display("timeout: no ack from address %0d within 20 cycles", adr);
		end
		@(posedge clk);
		req <= '0;
	endtask

	task automatic wb_write(input logic [wb_map_pkg::WB_AW-1:0] adr, input dp_pkg::word_t dat);
		dp_pkg::word_t unused;
		wb_cycle(1'b1, adr, dat, unused);
	endtask

	task automatic wb_read(input logic [wb_map_pkg::WB_AW-1:0] adr, output dp_pkg::word_t rd);
		wb_cycle(1'b0, adr, '0, rd);
	endtask

	task automatic run_step(input dp_pkg::src_mask_t src, input dp_pkg::dst_mask_t dst,
		input dp_pkg::alu_op_e op, input logic [15:0] imm);
		wb_write(wb_map_pkg::ADDR_SRC, dp_pkg::word_t'(src));
		wb_write(wb_map_pkg::ADDR_DST, dp_pkg::word_t'(dst));
		wb_write(wb_map_pkg::ADDR_EXEC, {imm, 12'd0, op});
	endtask

	task automatic load_reg(input int k, input dp_pkg::word_t val);
		wb_write(wb_map_pkg::ADDR_INPORT, val);
		run_step(src_sel(int'(dp_pkg::SRC_INPORT)), dst_sel(bank_dst(k)), dp_pkg::ADD, 16'd0);
		exp_regs[k] = val;
		inport_model = val;
	endtask

	// step without loads, then read back the latched bus.
	task automatic expect_source(input dp_pkg::src_mask_t src, input logic [15:0] imm,
		input dp_pkg::word_t exp, input string what);
		dp_pkg::word_t got;
		run_step(src, '0, dp_pkg::ADD, imm);
		wb_read(wb_map_pkg::ADDR_BUS, got);
		check_word(got, exp, what);
	endtask

	task automatic check_bank();
		for (int k = 0; k < 20; k++)
			expect_source(src_sel(bank_src(k)), 16'd0, exp_regs[k], $sformatf("bank %0d", k));
	endtask

	task automatic alu_case(input dp_pkg::alu_op_e op, input dp_pkg::word_t a,
		input dp_pkg::word_t b);
		dp_pkg::word_t lo;
		dp_pkg::word_t hi;
		load_reg(1, a);
		load_reg(2, b);
		run_step(src_sel(int'(dp_pkg::SRC_R0) + 1), dst_sel(dp_pkg::DST_Y), op, 16'd0);
		run_step(src_sel(int'(dp_pkg::SRC_R0) + 2), dst_sel(dp_pkg::DST_Z), op, 16'd0);
		run_step(src_sel(int'(dp_pkg::SRC_ZLO)), dst_sel(dp_pkg::DST_OUTPORT), op, 16'd0);
		wb_read(wb_map_pkg::ADDR_OUTPORT, lo);
		run_step(src_sel(int'(dp_pkg::SRC_ZHI)), dst_sel(dp_pkg::DST_OUTPORT), op, 16'd0);
		wb_read(wb_map_pkg::ADDR_OUTPORT, hi);
		check_op(op, lo, hi, expected_alu(op, a, b));
	endtask

	task automatic test_reset();
		dp_pkg::word_t got;
		wb_read(wb_map_pkg::ADDR_OUTPORT, got);
		check_word(got, '0, "outport after reset");
		wb_read(wb_map_pkg::ADDR_BUS, got);
		check_word(got, '0, "bus after reset");
	endtask

	task automatic test_source_walk();
		for (int k = 0; k < 20; k++)
			load_reg(k, dp_pkg::word_t'(2 * (k + 1)));
		check_bank();
		// inport gets a value no bank register holds.
		wb_write(wb_map_pkg::ADDR_INPORT, 32'h1357_9bdf);
		inport_model = 32'h1357_9bdf;
		expect_source(src_sel(int'(dp_pkg::SRC_INPORT)), 16'd0, inport_model, "inport");
		expect_source(src_sel(int'(dp_pkg::SRC_ZHI)), 16'h00a5, '0, "zhigh");
		expect_source(src_sel(int'(dp_pkg::SRC_ZLO)), 16'h00a5, '0, "zlow");
		expect_source(src_sel(int'(dp_pkg::SRC_C)), 16'hff9c, 32'hffff_ff9c, "c negative");
		expect_source(src_sel(int'(dp_pkg::SRC_C)), 16'h1234, 32'h0000_1234, "c positive");
	endtask

	task automatic test_priority();
		expect_source(src_sel(3) | src_sel(int'(dp_pkg::SRC_HI)) | src_sel(int'(dp_pkg::SRC_C)),
			16'h7777, exp_regs[3], "r3 over hi and c");
		expect_source(src_sel(int'(dp_pkg::SRC_HI)) | src_sel(int'(dp_pkg::SRC_MDR)),
			16'd0, exp_regs[16], "hi over mdr");
		expect_source('0, 16'd0, '0, "empty mask");
	endtask

	task automatic test_alu();
		dp_pkg::word_t a;
		dp_pkg::word_t b;
		for (int i = 0; i <= 11; i++)
		begin
			a = next_rand();
			b = next_rand();
			alu_case(dp_pkg::alu_op_e'(i), a, b);
		end
	endtask

	task automatic test_corners();
		alu_case(dp_pkg::DIV, next_rand(), '0);
		alu_case(dp_pkg::MUL, 32'hffff_fff9, 32'hffff_fffd);
		alu_case(dp_pkg::MUL, 32'hffff_fffb, 32'd3);
		alu_case(dp_pkg::MUL, 32'h8000_0000, 32'd2);
	endtask

	task automatic test_wishbone();
		dp_pkg::word_t bus_before;
		dp_pkg::word_t out_before;
		dp_pkg::word_t got;
		// a stray step would now move inport to outport.
		wb_write(wb_map_pkg::ADDR_INPORT, 32'h2468_ace0);
		inport_model = 32'h2468_ace0;
		wb_write(wb_map_pkg::ADDR_SRC, dp_pkg::word_t'(src_sel(int'(dp_pkg::SRC_INPORT))));
		wb_write(wb_map_pkg::ADDR_DST, dp_pkg::word_t'(dst_sel(dp_pkg::DST_OUTPORT)));
		wb_read(wb_map_pkg::ADDR_BUS, bus_before);
		wb_read(wb_map_pkg::ADDR_OUTPORT, out_before);
		@(posedge clk);
		req.cyc <= 1'b1;
		req.we <= 1'b1;
		req.adr <= wb_map_pkg::ADDR_EXEC;
		req.dat <= 32'h0000_0008;
		for (int n = 0; n < 6; n++)
		begin
			@(negedge clk);
			if (ack)
			begin
				errors++;
				$display("ack seen while cyc was high without stb at t=%0t", $time);
			end
		end
		@(posedge clk);
		req <= '0;
		wb_write(3'd6, 32'hdead_beef);
		wb_write(3'd7, 32'h0bad_f00d);
		wb_read(wb_map_pkg::ADDR_BUS, got);
		check_word(got, bus_before, "bus after unmapped writes");
		wb_read(wb_map_pkg::ADDR_OUTPORT, got);
		check_word(got, out_before, "outport after unmapped writes");
		check_bank();
		expect_source(src_sel(int'(dp_pkg::SRC_INPORT)), 16'd0, inport_model, "inport kept");
	endtask

	initial
	begin
		rst_n <= 1'b0;
		req <= '0;
		errors = 0;
		checks = 0;
		timeouts = 0;
		lcg_state = 32'hb8bc_89d6;
		inport_model = '0;
		for (int k = 0; k < 20; k++)
			exp_regs[k] = '0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		test_reset();
		test_source_walk();
		test_priority();
		test_alu();
		test_corners();
		test_wishbone();
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// File: datapath.f
rtl/dp_pkg.sv
rtl/wb_map_pkg.sv
rtl/wb_micro_port.sv
rtl/reg_bank.sv
rtl/bus_mux.sv
rtl/alu.sv
rtl/datapath_top.sv
verification/datapath_sva.sv
verification/datapath_tb.sv

// File: run_sim.sh
#!/bin/sh
verilator --binary --assert --top-module datapath_tb -f datapath.f -o datapath_sim \
	&& ./obj_dir/datapath_sim | tee /dev/stderr | grep "Simulation finished: PASS" > /dev/null \
	&& echo "run_sim: simulation passed" \
	|| { echo "run_sim: simulation failed or did not build"; exit 1; }
